// ==== bitbrick.sv ====
module bitbrick (
    input  logic [fusion_pkg::brick_w-1:0]   x,
    input  logic [fusion_pkg::brick_w-1:0]   y,
    input  logic                             sx,
    input  logic                             sy,
    output logic [fusion_pkg::brick_p_w-1:0] p
);
    import fusion_pkg::*;

    // Slices widened to 3 bits, signed or zero extended
    logic [brick_w:0] xe;
    logic [brick_w:0] ye;
    // Baugh-Wooley partial product rows
    logic [brick_w:0] pp0;
    logic [brick_w:0] pp1;
    logic [brick_w:0] pp2;
    // Adder tree sums and carries
    logic c1;
    logic s2;
    logic c2a;
    logic c2b;
    logic s3;
    logic c3a;
    logic c3b;
    logic c5;

    assign xe = {sx & x[brick_w-1], x};
    assign ye = {sy & y[brick_w-1], y};

    // Terms that pair one sign bit with one magnitude bit are inverted
    assign pp0 = {~(xe[2] & ye[0]), xe[1] & ye[0], xe[0] & ye[0]};
    assign pp1 = {~(xe[2] & ye[1]), xe[1] & ye[1], xe[0] & ye[1]};
    assign pp2 = {xe[2] & ye[2], ~(xe[1] & ye[2]), ~(xe[0] & ye[2])};

    assign p[0] = pp0[0];

    // Column 1, half adder
    assign p[1] = pp0[1] ^ pp1[0];
    assign c1   = pp0[1] & pp1[0];

    // Column 2, full adder then half adder
    assign s2   = pp1[1] ^ pp2[0] ^ c1;
    assign c2a  = (pp1[1] & pp2[0]) | (pp1[1] & c1) | (pp2[0] & c1);
    assign p[2] = pp0[2] ^ s2;
    assign c2b  = pp0[2] & s2;

    // Column 3, full adder then full adder with the constant one folded in
    assign s3   = pp1[2] ^ pp2[1] ^ c2a;
    assign c3a  = (pp1[2] & pp2[1]) | (pp1[2] & c2a) | (pp2[1] & c2a);
    assign p[3] = ~(s3 ^ c2b);
    assign c3b  = s3 | c2b;

    // Column 4, the inverted carry out stands for the second constant one
    assign p[4] = pp2[2] ^ c3a ^ c3b;
    assign c5   = (pp2[2] & c3a) | (pp2[2] & c3b) | (c3a & c3b);
    assign p[5] = ~c5;

endmodule

// ==== bitbrick_array.sv ====
module bitbrick_array (
    input  fusion_pkg::mac_req_t        req,
    output fusion_pkg::brick_products_t products
);
    import fusion_pkg::*;

    // Sign controls, one pair per brick
    logic [num_bricks-1:0] brick_sx;
    logic [num_bricks-1:0] brick_sy;

    //////////////////////////////
    // Sign control
    //////////////////////////////

    // A slice is signed only when it carries the MSBs of a number
    // at the current precision
    always_comb begin
        logic [3:0] idx;
        logic       x_top;
        logic       y_top;
        idx   = '0;
        x_top = 1'b0;
        y_top = 1'b0;
        for (int i = 0; i < num_bricks; i++) begin
            // idx bits are x nibble, y nibble, x slice, y slice
            idx = 4'(i);
            case (req.mode)
                mode_2x2: begin
                    // Every slice is a number of its own
                    x_top = 1'b1;
                    y_top = 1'b1;
                end
                mode_4x4: begin
                    // Upper slice of each nibble
                    x_top = idx[1];
                    y_top = idx[0];
                end
                default: begin
                    // Upper slice of the upper nibble only
                    x_top = idx[3] & idx[1];
                    y_top = idx[2] & idx[0];
                end
            endcase
            brick_sx[i] = req.sx & x_top;
            brick_sy[i] = req.sy & y_top;
        end
    end

    //////////////////////////////
    // Brick array
    //////////////////////////////

    // Slice offsets follow the brick index layout of brick_products_t
    for (genvar i = 0; i < num_bricks; i++) begin : g_brick
        bitbrick u_bitbrick (
            .x  (req.x[(i / 8) * nib_w + ((i / 2) % 2) * brick_w +: brick_w]),
            .y  (req.y[((i / 4) % 2) * nib_w + (i % 2) * brick_w +: brick_w]),
            .sx (brick_sx[i]),
            .sy (brick_sy[i]),
            .p  (products[i])
        );
    end

endmodule

// ==== fused_accumulator.sv ====
module fused_accumulator (
    input  logic                         clk,
    input  logic                         nrst,
    input  fusion_pkg::stage_t           stage,
    output logic [fusion_pkg::sum_w-1:0] sum
);
    import fusion_pkg::*;

    // Nibble products, block order hh hl lh ll from the top
    logic [num_blocks-1:0][nib_p_w-1:0] nib_p;
    // Nibble product holds a signed result
    logic [num_blocks-1:0]              nib_signed;
    // Per-mode products
    logic [2*operand_w-1:0]             prod_8x8;
    logic [field_4x4_w-1:0]             prod_4x4;
    logic [field_2x2_w-1:0]             prod_2x2;

    function automatic logic [nib_p_w-1:0] sext_brick(input logic [brick_p_w-1:0] v);
        return {{(nib_p_w-brick_p_w){v[brick_p_w-1]}}, v};
    endfunction

    //////////////////////////////
    // Brick reduction
    //////////////////////////////

    always_comb begin
        prod_2x2 = '0;
        for (int b = 0; b < num_blocks; b++) begin
            // Brick weights inside a block are 1, 4, 4 and 16
            nib_p[b] = sext_brick(stage.products[b*4])
                     + (sext_brick(stage.products[b*4+1]) << brick_w)
                     + (sext_brick(stage.products[b*4+2]) << brick_w)
                     + (sext_brick(stage.products[b*4+3]) << (2 * brick_w));
        end
        // 2x2 mode adds all sixteen brick products as they are
        for (int i = 0; i < num_bricks; i++) begin
            prod_2x2 += {{(field_2x2_w-brick_p_w){stage.products[i][brick_p_w-1]}},
                         stage.products[i]};
        end
    end

    // Which nibble products are signed
    always_comb begin
        if (stage.mode == mode_4x4) begin
            nib_signed = {num_blocks{stage.sx | stage.sy}};
        end else begin
            // Only the upper nibble of x or y carries a sign
            nib_signed = {stage.sx | stage.sy, stage.sx, stage.sy, 1'b0};
        end
    end

    always_comb begin
        logic [2*operand_w-1:0] nib_ext;
        nib_ext  = '0;
        prod_8x8 = '0;
        prod_4x4 = '0;
        for (int b = 0; b < num_blocks; b++) begin
            nib_ext = {{(2*operand_w-nib_p_w){nib_p[b][nib_p_w-1] & nib_signed[b]}}, nib_p[b]};
            // Shift is 0 for ll, one nibble for hl and lh, two for hh
            prod_8x8 += nib_ext << (((b >> 1) + (b & 1)) * nib_w);
            prod_4x4 += nib_ext[field_4x4_w-1:0];
        end
    end

    //////////////////////////////
    // Accumulator
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!nrst) begin
            sum <= '0;
        end else if (stage.restart) begin
            // Mode switched, the entry that came with it is dropped
            sum <= '0;
        end else if (stage.valid) begin
            case (stage.mode)
                mode_8x8: begin
                    sum <= sum + {{(sum_w-2*operand_w){prod_8x8[2*operand_w-1]
                                  & (stage.sx | stage.sy)}}, prod_8x8};
                end
                mode_4x4: begin
                    sum <= {{(sum_w-field_4x4_w){1'b0}}, sum[field_4x4_w-1:0] + prod_4x4};
                end
                mode_2x2: begin
                    sum <= {{(sum_w-field_2x2_w){1'b0}}, sum[field_2x2_w-1:0] + prod_2x2};
                end
                default: begin
                    sum <= '0;
                end
            endcase
        end
    end

endmodule

// ==== fusion_pkg.sv ====
package fusion_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    // Input operand, one per side
    localparam int operand_w = 8;
    // Operand slice seen by one bitbrick
    localparam int brick_w = 2;
    // Signed 3x3 product of two extended slices
    localparam int brick_p_w = 6;
    localparam int num_bricks = 16;

    // Four bricks fuse into one nibble block
    localparam int nib_w = 4;
    localparam int nib_p_w = 8;
    localparam int num_blocks = 4;

    // Running sum and the narrower fields used by the fused modes
    localparam int sum_w = 20;
    localparam int field_4x4_w = 12;
    localparam int field_2x2_w = 10;

    //////////////////////////////
    // Types
    //////////////////////////////

    // Symmetric precisions, mode_none only seen as the reset value of the last mode
    typedef enum logic [1:0] {
        mode_2x2  = 2'd0,
        mode_4x4  = 2'd1,
        mode_8x8  = 2'd2,
        mode_none = 2'd3
    } mode_t;

    // One operand pair with its sign controls
    typedef struct packed {
        logic [operand_w-1:0] x;
        logic [operand_w-1:0] y;
        logic                 sx;
        logic                 sy;
        mode_t                mode;
    } mac_req_t;

    // Index is {x nibble, y nibble, x slice, y slice}, so block hh sits at the top
    typedef logic [num_bricks-1:0][brick_p_w-1:0] brick_products_t;

    // Registered brick products on their way to the reduction
    typedef struct packed {
        logic            valid;
        logic            restart;
        mode_t           mode;
        logic            sx;
        logic            sy;
        brick_products_t products;
    } stage_t;

endpackage

// ==== fusion_unit.sv ====
module fusion_unit (
    input  logic                         clk,
    input  logic                         nrst,
    input  fusion_pkg::mac_req_t         req,
    input  logic                         req_valid,
    output logic [fusion_pkg::sum_w-1:0] sum
);
    import fusion_pkg::*;

    // Raw brick products, combinational from req
    brick_products_t products;
    // Registered products with mode, signs and restart
    stage_t          stage;

    // Producer, sixteen bitbricks
    bitbrick_array u_bitbrick_array (
        .req      (req),
        .products (products)
    );

    // Buffer, one cycle behind the bricks
    product_stage u_product_stage (
        .clk       (clk),
        .nrst      (nrst),
        .req       (req),
        .req_valid (req_valid),
        .products  (products),
        .stage     (stage)
    );

    // Consumer, reduction and running sum
    fused_accumulator u_fused_accumulator (
        .clk   (clk),
        .nrst  (nrst),
        .stage (stage),
        .sum   (sum)
    );

endmodule

// ==== product_stage.sv ====
module product_stage (
    input  logic                        clk,
    input  logic                        nrst,
    input  fusion_pkg::mac_req_t        req,
    input  logic                        req_valid,
    input  fusion_pkg::brick_products_t products,
    output fusion_pkg::stage_t          stage
);
    import fusion_pkg::*;

    // Mode presented on the previous cycle
    mode_t last_mode;

    //////////////////////////////
    // Stage register
    //////////////////////////////

    always_ff @(posedge clk) begin
        // Payload follows the bricks every cycle
        stage.mode     <= req.mode;
        stage.sx       <= req.sx;
        stage.sy       <= req.sy;
        stage.products <= products;

        if (!nrst) begin
            // Never a legal input, so the first cycle out of reset restarts
            last_mode     <= mode_none;
            stage.valid   <= 1'b0;
            stage.restart <= 1'b0;
        end else begin
            last_mode   <= req.mode;
            stage.valid <= req_valid;
            // Mode is tracked whether or not the request is valid
            stage.restart <= (req.mode != last_mode);
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Compile the RTL and the testbench with Verilator, then run the simulation
cd "$(dirname "$0")" || exit 1
verilator --binary --top-module tb_fusion_unit -f sim.f -o tb_fusion_unit \
    && ./obj_dir/tb_fusion_unit > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run did not complete"; exit 1; }
cat sim.log
# Any failed check or a timeout leaves the fail message in the log
grep -q "RESULT: FAIL" sim.log && exit 1 || exit 0

// ==== sim.f ====
fusion_pkg.sv
bitbrick.sv
bitbrick_array.sv
product_stage.sv
fused_accumulator.sv
fusion_unit.sv
tb_fusion_unit.sv

// ==== tb_fusion_unit.sv ====
module tb_fusion_unit;
    import fusion_pkg::*;

    // One table row with the expected sum filled in before the run
    typedef struct packed {
        mac_req_t           req;
        logic               valid;
        logic [sum_w-1:0]   expected;
    } entry_t;

    logic             clk;
    logic             nrst;
    mac_req_t         req;
    logic             req_valid;
    logic [sum_w-1:0] sum;

    entry_t tab[$];
    int     error_count = 0;
    int     check_count = 0;
    int     cycle_count = 0;
    int     cycle_limit = 0;

    fusion_unit DUT (
        .clk       (clk),
        .nrst      (nrst),
        .req       (req),
        .req_valid (req_valid),
        .sum       (sum)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Free running cycle count that stops a run which never reaches its end
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Reads the w-bit field of v at lsb as two's complement when signed_on
    function automatic int field_value(input logic [operand_w-1:0] v, input int lsb,
                                       input int w, input logic signed_on);
        int u;
        u = (int'(v) >> lsb) & ((1 << w) - 1);
        if (signed_on && u[w-1]) begin
            u = u - (1 << w);
        end
        return u;
    endfunction

    // Product of one request at its precision
    function automatic int mode_product(input mac_req_t r);
        int p;
        p = 0;
        case (r.mode)
            mode_8x8: begin
                p = field_value(r.x, 0, 8, r.sx) * field_value(r.y, 0, 8, r.sy);
            end
            mode_4x4: begin
                // Four nibble cross products
                for (int i = 0; i < 2; i++) begin
                    for (int j = 0; j < 2; j++) begin
                        p += field_value(r.x, 4 * i, 4, r.sx) * field_value(r.y, 4 * j, 4, r.sy);
                    end
                end
            end
            default: begin
                // Sixteen 2-bit slice cross products
                for (int i = 0; i < 4; i++) begin
                    for (int j = 0; j < 4; j++) begin
                        p += field_value(r.x, 2 * i, 2, r.sx) * field_value(r.y, 2 * j, 2, r.sy);
                    end
                end
            end
        endcase
        return p;
    endfunction

    // Mask of the sum field that wraps in each mode
    function automatic int field_mask(input mode_t m);
        case (m)
            mode_8x8: return 32'h000f_ffff;
            mode_4x4: return 32'h0000_0fff;
            default:  return 32'h0000_03ff;
        endcase
    endfunction

    // Walks the table in order where a mode change clears and drops its own entry
    task automatic fill_expected();
        int     acc;
        mode_t  prev_mode;
        entry_t e;
        acc       = 0;
        prev_mode = mode_none;
        foreach (tab[k]) begin
            e = tab[k];
            if (e.req.mode != prev_mode) begin
                acc = 0;
            end else if (e.valid) begin
                acc = (acc + mode_product(e.req)) & field_mask(e.req.mode);
            end
            prev_mode  = e.req.mode;
            e.expected = sum_w'(acc);
            tab[k]     = e;
        end
    endtask

    //////////////////////////////
    // Stimulus table
    //////////////////////////////

    task automatic add_entry(input logic [operand_w-1:0] x, input logic [operand_w-1:0] y,
                             input logic sx, input logic sy, input mode_t mode,
                             input logic valid);
        entry_t e;
        e.req.x    = x;
        e.req.y    = y;
        e.req.sx   = sx;
        e.req.sy   = sy;
        e.req.mode = mode;
        e.valid    = valid;
        e.expected = '0;
        tab.push_back(e);
    endtask

    task automatic build_table();
        // First entry after reset always restarts
        add_entry(8'd5, 8'd7, 1'b0, 1'b0, mode_8x8, 1'b1);
        add_entry(8'd5, 8'd7, 1'b0, 1'b0, mode_8x8, 1'b1);
        // Enough unsigned 255 x 255 products to wrap 20 bits
        repeat (17) add_entry(8'hff, 8'hff, 1'b0, 1'b0, mode_8x8, 1'b1);
        // -128 x -128
        repeat (3) add_entry(8'h80, 8'h80, 1'b1, 1'b1, mode_8x8, 1'b1);
        // Both mixed sign pairs give -32640
        repeat (3) add_entry(8'h80, 8'hff, 1'b1, 1'b0, mode_8x8, 1'b1);
        repeat (3) add_entry(8'hff, 8'h80, 1'b0, 1'b1, mode_8x8, 1'b1);
        // Hold with valid low and the mode unchanged
        repeat (4) add_entry(8'h12, 8'h34, 1'b1, 1'b1, mode_8x8, 1'b0);
        add_entry(8'hfd, 8'h07, 1'b1, 1'b1, mode_8x8, 1'b1);

        // The entry that switches to 4x4 is dropped
        add_entry(8'hff, 8'hff, 1'b0, 1'b0, mode_4x4, 1'b1);
        // 900 per entry wraps the 12-bit field
        repeat (5) add_entry(8'hff, 8'hff, 1'b0, 1'b0, mode_4x4, 1'b1);
        repeat (3) add_entry(8'h88, 8'h88, 1'b1, 1'b1, mode_4x4, 1'b1);
        repeat (3) add_entry(8'h88, 8'hff, 1'b1, 1'b0, mode_4x4, 1'b1);
        add_entry(8'h7f, 8'hff, 1'b1, 1'b0, mode_4x4, 1'b1);

        // 2x2 entered with valid low still clears
        add_entry(8'h00, 8'h00, 1'b0, 1'b0, mode_2x2, 1'b0);
        repeat (8) add_entry(8'hff, 8'hff, 1'b0, 1'b0, mode_2x2, 1'b1);
        repeat (3) add_entry(8'haa, 8'haa, 1'b1, 1'b1, mode_2x2, 1'b1);
        repeat (3) add_entry(8'haa, 8'h55, 1'b1, 1'b1, mode_2x2, 1'b1);
        repeat (4) add_entry(8'h3c, 8'hc3, 1'b1, 1'b0, mode_2x2, 1'b0);

        // Back to 8x8 with valid low and then a hold at zero
        repeat (4) add_entry(8'h99, 8'h66, 1'b1, 1'b1, mode_8x8, 1'b0);

        // One random back to back stream per mode
        repeat (24) add_entry(8'($urandom()), 8'($urandom()), 1'($urandom()),
                              1'($urandom()), mode_2x2, 1'b1);
        repeat (24) add_entry(8'($urandom()), 8'($urandom()), 1'($urandom()),
                              1'($urandom()), mode_4x4, 1'b1);
        repeat (24) add_entry(8'($urandom()), 8'($urandom()), 1'($urandom()),
                              1'($urandom()), mode_8x8, 1'b1);
        // Random valid in 4x4
        repeat (16) add_entry(8'($urandom()), 8'($urandom()), 1'($urandom()),
                              1'($urandom()), mode_4x4, 1'($urandom()));
    endtask

    //////////////////////////////
    // Checking and main flow
    //////////////////////////////

    task automatic compare_sum(input int idx, input logic [sum_w-1:0] expected);
        check_count++;
        if (sum !== expected) begin
            error_count++;
            if (idx < 0) begin
                $display("** Error at time %0t: sum after reset expected %05h, got %05h",
                         $time, expected, sum);
            end else begin
                $display("** Error at time %0t: entry %0d expected %05h, got %05h",
                         $time, idx, expected, sum);
            end
        end
    endtask

    initial begin
        void'($urandom(32'h35c1_4713));
        nrst      <= 1'b0;
        req       <= '0;
        req_valid <= 1'b0;
        build_table();
        fill_expected();
        // Table plus 4 reset cycles plus margin
        cycle_limit = tab.size() + 4 + 20;

        repeat (4) @(posedge clk);
        nrst <= 1'b1;

        // Entry k is driven here and shows in the sum two edges later
        for (int k = 0; k < tab.size() + 2; k++) begin
            if (k < tab.size()) begin
                req       <= tab[k].req;
                req_valid <= tab[k].valid;
            end else begin
                req_valid <= 1'b0;
            end
            @(negedge clk);
            if (k >= 2) begin
                compare_sum(k - 2, tab[k-2].expected);
            end else begin
                compare_sum(-1, '0);
            end
            @(posedge clk);
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
